// ==== Bender.yml ====
package:
  name: eeprom_ctrl

sources:
  - files:
      - rtl/eeprom_pkg.sv
      - rtl/i2c_bit_if.sv
      - rtl/i2c_bit_engine.sv
      - rtl/eeprom_sequencer.sv
      - rtl/eeprom_ctrl_top.sv
  - target: test
    files:
      - dv/eeprom_model.sv
      - dv/tb_eeprom_ctrl.sv

// ==== dv/eeprom_model.sv ====
module eeprom_model (
    input logic CLK,
    input logic scl,
    inout wire  sda
);

    localparam int WRITE_BUSY_CLKS = 300; // internal write cycle after stop

    localparam logic [2:0] P_IDLE = 3'd0;
    localparam logic [2:0] P_CTRL = 3'd1;
    localparam logic [2:0] P_ADDR = 3'd2;
    localparam logic [2:0] P_DATA = 3'd3;
    localparam logic [2:0] P_READ = 3'd4;
    localparam logic [2:0] P_SKIP = 3'd5; // ignore the bus until stop

    logic [7:0]                       mem [0:(1 << eeprom_pkg::ADDR_BITS) - 1];
    logic [2:0]                       phase = P_IDLE;
    logic [3:0]                       nclk = 4'd0; // SCL rising edges in this byte
    logic [7:0]                       shreg;
    logic [7:0]                       out_byte;
    logic                             drive_low = 1'b0;
    logic                             acked;
    logic                             write_pending = 1'b0;
    logic [eeprom_pkg::ADDR_BITS-1:0] ptr;
    logic [7:0]                       wr_data;
    int                               busy_cnt = 0;
    eeprom_pkg::control_byte_u        ctrl;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < (1 << eeprom_pkg::ADDR_BITS); i++)
            mem[i] = 8'hff; // erased
    end

    always @(posedge CLK)
    begin
        if (busy_cnt > 0)
            busy_cnt = busy_cnt - 1;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            phase = P_CTRL;
            nclk  = 4'd0;
        end
    end

    // stop, a pending write goes into the array here
    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            if (write_pending)
            begin
                mem[ptr] = wr_data;
                busy_cnt = WRITE_BUSY_CLKS;
            end
            write_pending = 1'b0;
            phase         = P_IDLE;
        end
    end

    always @(posedge scl)
    begin
        if (phase != P_IDLE && phase != P_SKIP)
        begin
            nclk = nclk + 4'd1;
            if (nclk <= 4'd8)
                shreg = {shreg[6:0], sda !== 1'b0};
        end
    end

    always @(negedge scl)
    begin
        if (phase == P_IDLE || phase == P_SKIP || nclk == 4'd0)
            drive_low = 1'b0; // also the falling SCL that ends a start
        else if (nclk == 4'd8)
        begin
            case (phase)
                P_CTRL:
                begin
                    ctrl.raw = shreg;
                    acked    = ctrl.fields.dev_code == eeprom_pkg::DEVICE_CODE && busy_cnt == 0;
                end
                P_ADDR:
                begin
                    ptr   = {ctrl.fields.block, shreg};
                    acked = 1'b1;
                end
                P_DATA:
                begin
                    wr_data       = shreg;
                    write_pending = 1'b1;
                    acked         = 1'b1;
                end
                default:
                    acked = 1'b1; // master answers a read byte
            endcase
            drive_low = acked && phase != P_READ;
        end
        else if (nclk == 4'd9)
        begin
            nclk      = 4'd0;
            drive_low = 1'b0;
            if (!acked)
                phase = P_SKIP;
            else if (phase == P_CTRL && ctrl.fields.rw)
            begin
                ptr       = {ctrl.fields.block, ptr[7:0]};
                out_byte  = mem[ptr];
                phase     = P_READ;
                drive_low = !out_byte[7]; // msb ready before the first rising SCL
            end
            else if (phase == P_CTRL)
                phase = P_ADDR;
            else if (phase == P_ADDR)
                phase = P_DATA; // a repeated start may still turn this into a read
            else
                phase = P_SKIP; // single byte only
        end
        else if (phase == P_READ)
            drive_low = !out_byte[7 - nclk];
    end

endmodule

// ==== dv/tb_eeprom_ctrl.sv ====
module tb_eeprom_ctrl;

    localparam int AW = eeprom_pkg::ADDR_BITS;
    localparam int DW = eeprom_pkg::DATA_BITS;

    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_WAIT  = 2'd2;

    localparam int WAIT_CLKS = 320; // longer than the model's write cycle
    localparam int ROW_CLKS  = 400 * eeprom_pkg::QUARTER_CLKS;

    typedef struct packed {
        logic [1:0]    op;
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        logic          exp_nack;
        logic [DW-1:0] exp_rdata;
    } step_t;

    logic          CLK;
    logic          RESET;
    logic          wr;
    logic          rd;
    logic [AW-1:0] addr;
    logic [DW-1:0] wdata;
    logic          ready;
    logic          ack;
    logic          nack;
    logic [DW-1:0] rdata;
    logic          scl;
    wire           sda;

    step_t         steps[$];
    logic [DW-1:0] ref_mem [0:(1 << AW) - 1];
    logic          write_cycle; // a stored write still busy inside the model
    logic          table_built;
    int            wait_rows;
    int            pending = 0;

    pullup (sda);

    eeprom_ctrl_top i_eeprom_ctrl_top (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .ready (ready),
        .ack   (ack),
        .nack  (nack),
        .rdata (rdata),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_model i_eeprom_model (
        .CLK (CLK),
        .scl (scl),
        .sda (sda)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic fail_now();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_data(
        input logic [DW-1:0] got,
        input logic [DW-1:0] exp,
        input string         what
    );
        if (got !== exp)
        begin
            $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic add_step(input logic [1:0] op, input logic [AW-1:0] a, input logic [DW-1:0] d);
        step_t s;
        s.op        = op;
        s.addr      = a;
        s.data      = d;
        s.exp_nack  = op != OP_WAIT && write_cycle; // model refuses its control byte
        s.exp_rdata = ref_mem[a];
        if (op == OP_WAIT)
        begin
            write_cycle = 1'b0;
            wait_rows++;
        end
        else if (op == OP_WRITE && !write_cycle)
        begin
            ref_mem[a]  = d;
            write_cycle = 1'b1;
        end
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [AW-1:0] a;
        logic [AW-1:0] last_written;
        logic [DW-1:0] d;
        logic          have_written;
        void'($urandom(32'hb014));
        for (int i = 0; i < (1 << AW); i++)
            ref_mem[i] = 8'hff;
        write_cycle  = 1'b0;
        wait_rows    = 0;
        have_written = 1'b0;
        last_written = '0;
        add_step(OP_WRITE, 11'h123, 8'ha5);
        add_step(OP_WAIT, '0, '0);
        add_step(OP_READ, 11'h123, '0);
        // same word address in every block
        for (int b = 0; b < 8; b++)
        begin
            d = DW'($urandom);
            add_step(OP_WRITE, {b[2:0], 8'h3c}, d);
            add_step(OP_WAIT, '0, '0);
        end
        for (int b = 0; b < 8; b++)
            add_step(OP_READ, {b[2:0], 8'h3c}, '0);
        add_step(OP_WRITE, 11'h4e7, 8'h96);
        add_step(OP_READ, 11'h4e7, '0); // lands in the write cycle
        add_step(OP_WAIT, '0, '0);
        add_step(OP_READ, 11'h4e7, '0);
        for (int i = 0; i < 24; i++)
        begin
            a = AW'($urandom);
            d = DW'($urandom);
            if ($urandom % 2)
            begin
                add_step(OP_WRITE, a, d);
                add_step(OP_WAIT, '0, '0);
                last_written = a;
                have_written = 1'b1;
            end
            else if (have_written && ($urandom % 2))
                add_step(OP_READ, last_written, '0);
            else
                add_step(OP_READ, a, '0); // mostly erased locations
        end
    endtask

    // entered on a falling edge and left on the one that sees ack
    task automatic run_request(input step_t s);
        wr    = s.op == OP_WRITE;
        rd    = s.op == OP_READ;
        addr  = s.addr;
        wdata = s.data;
        while (!ready)
            @(negedge CLK); // request held while the controller is busy
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        while (!ack)
            @(negedge CLK);
    endtask

    // request and ack bookkeeping on the values seen at each rising edge
    always @(posedge CLK)
    begin
        if (RESET !== 1'b0)
            pending = 0;
        else if (ready !== (pending == 0))
        begin
            $display("ready is %b with %0d request(s) outstanding at time %0t",
                     ready, pending, $time);
            fail_now();
        end
        else if (ack && pending == 0)
        begin
            $display("ack pulse without an accepted request at time %0t", $time);
            fail_now();
        end
        else
        begin
            if (ack)
                pending = 0;
            if (ready && (wr || rd))
                pending = 1;
        end
    end

    initial
    begin
        int limit;
        wait (table_built === 1'b1);
        limit = steps.size() * ROW_CLKS + wait_rows * WAIT_CLKS;
        repeat (limit) @(posedge CLK);
        $display("timeout: a transaction never completed within %0d clock cycles", limit);
        fail_now();
    end

    initial
    begin
        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wdata       = '0;
        table_built = 1'b0;
        build_table();
        table_built = 1'b1;
        repeat (4) @(negedge CLK);
        RESET = 1'b0;
        check_flag(scl, 1'b1, "scl after reset");
        check_flag(sda, 1'b1, "sda after reset");
        check_flag(ack, 1'b0, "ack after reset");
        check_flag(nack, 1'b0, "nack after reset");
        for (int i = 0; i < steps.size(); i++)
        begin
            if (steps[i].op == OP_WAIT)
                repeat (WAIT_CLKS) @(negedge CLK);
            else
            begin
                run_request(steps[i]);
                check_flag(nack, steps[i].exp_nack, $sformatf("row %0d nack", i));
                if (steps[i].op == OP_READ && !steps[i].exp_nack)
                    check_data(rdata, steps[i].exp_rdata, $sformatf("row %0d rdata", i));
                check_flag(scl, 1'b1, $sformatf("row %0d scl after stop", i));
                check_flag(sda, 1'b1, $sformatf("row %0d sda after stop", i));
            end
        end
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== list.f ====
rtl/eeprom_pkg.sv
rtl/i2c_bit_if.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_sequencer.sv
rtl/eeprom_ctrl_top.sv
dv/eeprom_model.sv
dv/tb_eeprom_ctrl.sv

// ==== rtl/eeprom_ctrl_top.sv ====
module eeprom_ctrl_top (
    input  logic                             CLK,
    input  logic                             RESET,
    input  logic                             wr,
    input  logic                             rd,
    input  logic [eeprom_pkg::ADDR_BITS-1:0] addr,
    input  logic [eeprom_pkg::DATA_BITS-1:0] wdata,
    output logic                             ready,
    output logic                             ack,
    output logic                             nack,
    output logic [eeprom_pkg::DATA_BITS-1:0] rdata,
    output logic                             scl,
    inout  wire                              sda
);

    logic sda_drive_low;
    logic sda_in;

    i2c_bit_if bus ();

    eeprom_sequencer i_eeprom_sequencer (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .ready (ready),
        .ack   (ack),
        .nack  (nack),
        .rdata (rdata),
        .bus   (bus.seq)
    );

    i2c_bit_engine i_i2c_bit_engine (
        .CLK           (CLK),
        .RESET         (RESET),
        .bus           (bus.engine),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    // open drain, high level comes from the external pullup
    assign sda    = sda_drive_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

endmodule

// ==== rtl/eeprom_pkg.sv ====
package eeprom_pkg;

    // one CLK per SCL quarter, so a bit time is 4 CLK
    localparam logic [1:0] QUARTER_CLKS = 2'd1;

    // bit engine commands
    localparam logic [1:0] BIT_CMD_START = 2'd0;
    localparam logic [1:0] BIT_CMD_STOP  = 2'd1;
    localparam logic [1:0] BIT_CMD_WRITE = 2'd2;
    localparam logic [1:0] BIT_CMD_READ  = 2'd3;

    localparam logic [3:0] DEVICE_CODE = 4'b1010; // 24C16 family

    localparam int ADDR_BITS = 11; // 8 blocks x 256 bytes
    localparam int DATA_BITS = 8;

    // sequencer states
    localparam logic [3:0] ST_IDLE    = 4'd0;
    localparam logic [3:0] ST_START   = 4'd1;
    localparam logic [3:0] ST_CTRL_WR = 4'd2;
    localparam logic [3:0] ST_ADDR    = 4'd3;
    localparam logic [3:0] ST_DATA    = 4'd4;
    localparam logic [3:0] ST_RESTART = 4'd5;
    localparam logic [3:0] ST_CTRL_RD = 4'd6;
    localparam logic [3:0] ST_READ    = 4'd7;
    localparam logic [3:0] ST_STOP    = 4'd8;
    localparam logic [3:0] ST_DONE    = 4'd9;

    typedef struct packed {
        logic [3:0] dev_code;
        logic [2:0] block;    // address bits 10 to 8
        logic       rw;       // 1 for read
    } control_fields_t;

    // control byte, shifted as raw, built and decoded as fields
    typedef union packed {
        logic [7:0]      raw;
        control_fields_t fields;
    } control_byte_u;

endpackage

// ==== rtl/eeprom_sequencer.sv ====
module eeprom_sequencer (
    input  logic                             CLK,
    input  logic                             RESET,
    input  logic                             wr,
    input  logic                             rd,
    input  logic [eeprom_pkg::ADDR_BITS-1:0] addr,
    input  logic [eeprom_pkg::DATA_BITS-1:0] wdata,
    output logic                             ready,
    output logic                             ack,
    output logic                             nack,
    output logic [eeprom_pkg::DATA_BITS-1:0] rdata,
    i2c_bit_if.seq                           bus
);

    logic [3:0]                      state;
    logic [3:0]                      next_state;
    logic                            cmd_valid_r;
    logic                            nack_r;
    logic                            is_read;
    logic                            accept;
    logic                            byte_out;
    logic [7:0]                      word_addr;
    logic [eeprom_pkg::DATA_BITS-1:0] wdata_r;
    eeprom_pkg::control_byte_u       ctrl;

    assign ready  = state == eeprom_pkg::ST_IDLE;
    assign accept = ready && (wr || rd);
    assign ack    = state == eeprom_pkg::ST_DONE;
    assign nack   = nack_r;

    // states whose byte the slave must acknowledge
    assign byte_out = state == eeprom_pkg::ST_CTRL_WR || state == eeprom_pkg::ST_ADDR ||
                      state == eeprom_pkg::ST_DATA || state == eeprom_pkg::ST_CTRL_RD;

    assign bus.cmd_valid = cmd_valid_r;
    assign bus.last_read = state == eeprom_pkg::ST_READ; // single read always ends in no-ack

    always_comb
    begin
        next_state = state;
        case (state)
            eeprom_pkg::ST_IDLE:
                if (wr || rd)
                    next_state = eeprom_pkg::ST_START;
            eeprom_pkg::ST_START:
                if (bus.done)
                    next_state = eeprom_pkg::ST_CTRL_WR;
            eeprom_pkg::ST_CTRL_WR:
                if (bus.done)
                    next_state = bus.ack_n ? eeprom_pkg::ST_STOP : eeprom_pkg::ST_ADDR;
            eeprom_pkg::ST_ADDR:
            begin
                if (bus.done)
                begin
                    if (bus.ack_n)
                        next_state = eeprom_pkg::ST_STOP;
                    else if (is_read)
                        next_state = eeprom_pkg::ST_RESTART;
                    else
                        next_state = eeprom_pkg::ST_DATA;
                end
            end
            eeprom_pkg::ST_DATA, eeprom_pkg::ST_READ:
                if (bus.done)
                    next_state = eeprom_pkg::ST_STOP;
            eeprom_pkg::ST_RESTART:
                if (bus.done)
                    next_state = eeprom_pkg::ST_CTRL_RD;
            eeprom_pkg::ST_CTRL_RD:
                if (bus.done)
                    next_state = bus.ack_n ? eeprom_pkg::ST_STOP : eeprom_pkg::ST_READ;
            eeprom_pkg::ST_STOP:
                if (bus.done)
                    next_state = eeprom_pkg::ST_DONE;
            default:
                next_state = eeprom_pkg::ST_IDLE; // done lasts one cycle
        endcase
    end

    always_comb
    begin
        case (state)
            eeprom_pkg::ST_START, eeprom_pkg::ST_RESTART:
                bus.cmd = eeprom_pkg::BIT_CMD_START;
            eeprom_pkg::ST_STOP:
                bus.cmd = eeprom_pkg::BIT_CMD_STOP;
            eeprom_pkg::ST_READ:
                bus.cmd = eeprom_pkg::BIT_CMD_READ;
            default:
                bus.cmd = eeprom_pkg::BIT_CMD_WRITE;
        endcase
    end

    always_comb
    begin
        case (state)
            eeprom_pkg::ST_ADDR:
                bus.tx_byte = word_addr;
            eeprom_pkg::ST_DATA:
                bus.tx_byte = wdata_r;
            default:
                bus.tx_byte = ctrl.raw;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state       <= eeprom_pkg::ST_IDLE;
            cmd_valid_r <= 1'b0;
            nack_r      <= 1'b0;
        end
        else
        begin
            state <= next_state;
            // one command per state, issued on entry
            cmd_valid_r <= next_state != state && next_state != eeprom_pkg::ST_IDLE &&
                           next_state != eeprom_pkg::ST_DONE;
            if (accept)
                nack_r <= 1'b0;
            else if (bus.done && byte_out && bus.ack_n)
                nack_r <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            word_addr             <= addr[7:0];
            wdata_r               <= wdata;
            is_read               <= !wr; // write wins
            ctrl.fields.dev_code  <= eeprom_pkg::DEVICE_CODE;
            ctrl.fields.block     <= addr[eeprom_pkg::ADDR_BITS-1:8];
            ctrl.fields.rw        <= 1'b0;
        end
        else if (state == eeprom_pkg::ST_RESTART && bus.done)
        begin
            ctrl.fields.rw <= 1'b1;
        end

        if (state == eeprom_pkg::ST_READ && bus.done)
            rdata <= bus.rx_byte;
    end

endmodule

// ==== rtl/i2c_bit_engine.sv ====
module i2c_bit_engine (
    input  logic      CLK,
    input  logic      RESET,
    i2c_bit_if.engine bus,
    output logic      scl,
    output logic      sda_drive_low,
    input  logic      sda_in
);

    logic       busy;
    logic [1:0] clk_cnt;     // CLKs within a quarter
    logic [1:0] quarter;
    logic [3:0] bit_cnt;     // 0 to 8
    logic [7:0] shreg;
    logic [1:0] cmd_r;
    logic       last_read_r;
    logic       ack_n_r;
    logic       tick;
    logic       is_byte;
    logic       last_bit;
    logic       accept;

    assign accept  = !busy && bus.cmd_valid;
    assign tick    = clk_cnt == eeprom_pkg::QUARTER_CLKS - 2'd1;
    assign is_byte = cmd_r == eeprom_pkg::BIT_CMD_WRITE || cmd_r == eeprom_pkg::BIT_CMD_READ;

    // start and stop are a single bit time
    assign last_bit = !is_byte || bit_cnt == 4'd8;

    // done falls in quarter 3 of the last bit, with the ack already sampled
    assign bus.done    = busy && tick && quarter == 2'd3 && last_bit;
    assign bus.rx_byte = shreg;
    assign bus.ack_n   = ack_n_r;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy          <= 1'b0;
            clk_cnt       <= 2'd0;
            quarter       <= 2'd0;
            bit_cnt       <= 4'd0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end
        else if (!busy)
        begin
            if (bus.cmd_valid)
            begin
                busy    <= 1'b1;
                clk_cnt <= 2'd0;
                quarter <= 2'd0;
                bit_cnt <= 4'd0;
            end
        end
        else
        begin
            if (tick)
                clk_cnt <= 2'd0;
            else
                clk_cnt <= clk_cnt + 2'd1;

            if (tick)
            begin
                quarter <= quarter + 2'd1;
                case (quarter)
                    2'd0:
                    begin
                        // entering quarter 1, SDA may change while SCL is low
                        case (cmd_r)
                            eeprom_pkg::BIT_CMD_START:
                                sda_drive_low <= 1'b0; // release first for repeated start
                            eeprom_pkg::BIT_CMD_STOP:
                                sda_drive_low <= 1'b1;
                            eeprom_pkg::BIT_CMD_WRITE:
                                sda_drive_low <= bit_cnt != 4'd8 && !shreg[7];
                            default:
                                sda_drive_low <= bit_cnt == 4'd8 && !last_read_r;
                        endcase
                    end
                    2'd1:
                        scl <= 1'b1;
                    2'd2:
                    begin
                        if (cmd_r == eeprom_pkg::BIT_CMD_START)
                            sda_drive_low <= 1'b1; // falls with SCL high
                        else if (cmd_r == eeprom_pkg::BIT_CMD_STOP)
                            sda_drive_low <= 1'b0; // rises with SCL high
                    end
                    default:
                    begin
                        if (last_bit)
                        begin
                            busy <= 1'b0;
                            if (cmd_r != eeprom_pkg::BIT_CMD_STOP)
                                scl <= 1'b0; // bus stays claimed between commands
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 4'd1;
                            scl     <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    // command latch and sampling at the start of quarter 3
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cmd_r       <= bus.cmd;
            last_read_r <= bus.last_read;
            shreg       <= bus.tx_byte;
        end
        else if (busy && tick && quarter == 2'd2 && is_byte)
        begin
            if (bit_cnt == 4'd8)
                ack_n_r <= sda_in;
            else
                shreg <= {shreg[6:0], sda_in}; // writes shift out msb while reading back
        end
    end

endmodule

// ==== rtl/i2c_bit_if.sv ====
interface i2c_bit_if;

    // command width follows the package codes
    logic [$bits(eeprom_pkg::BIT_CMD_START)-1:0] cmd;
    logic                                        cmd_valid; // one cycle per command
    logic [7:0]                                  tx_byte;
    logic                                        last_read; // answer read with no-ack

    logic [7:0] rx_byte;
    logic       ack_n;     // 1 means slave did not acknowledge
    logic       done;

    modport seq (
        output cmd,
        output cmd_valid,
        output tx_byte,
        output last_read,
        input  rx_byte,
        input  ack_n,
        input  done
    );

    modport engine (
        input  cmd,
        input  cmd_valid,
        input  tx_byte,
        input  last_read,
        output rx_byte,
        output ack_n,
        output done
    );

endinterface
